/* controller.f */
+incdir+tests
source/ctrlPkg.sv
source/condEval.sv
source/instDecode.sv
source/ctrlSequencer.sv
source/controller.sv
tests/controller_checker.sv
tests/controllerTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Compile and run the controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module controllerTb -f controller.f \
	--Mdir build -o controllerSim

./build/controllerSim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log
then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tests/controllerVectors.svh */
`ifndef CONTROLLER_VECTORS_SVH
`define CONTROLLER_VECTORS_SVH

// Strobe bit order is branch, jump, memcMux, immMux, psrEn, pcEn, write, condRslt
typedef struct packed
{
	ctrlPkg::inst_t inst;
	ctrlPkg::psr_t psr;
	logic randPsr;
	logic [7:0] strobes;
	ctrlPkg::wbSel_t wb;
	ctrlPkg::regIdx_t dst;
	ctrlPkg::regIdx_t src;
	ctrlPkg::imm_t imm;
	ctrlPkg::aluOp_t alu;
	logic isLoad;
	ctrlPkg::regIdx_t ldDst;
	ctrlPkg::regIdx_t ldSrc;
} vecRow_t;

// psrB never satisfies its code
typedef struct packed
{
	ctrlPkg::cond_t code;
	ctrlPkg::psr_t psrA;
	logic metA;
	ctrlPkg::psr_t psrB;
} condRow_t;

task automatic fillTables();
	//////////////////////////////////////////////////
	// I-types
	addVector("ADDI", 16'h537A, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'h3, 4'h0, 8'h7A, ctrlPkg::aluAdd, 1'b0, 4'h0, 4'h0);
	addVector("ADDUI", 16'h6A05, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'hA, 4'h0, 8'h05, ctrlPkg::aluAddu, 1'b0, 4'h0, 4'h0);
	addVector("SUBI", 16'h91FF, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'h1, 4'h0, 8'hFF, ctrlPkg::aluSub, 1'b0, 4'h0, 4'h0);
	// No write for the compare
	addVector("CMPI", 16'hB280, 5'h00, 1'b1, 8'b0001_1100, ctrlPkg::wbAlu,
		4'h2, 4'h0, 8'h80, ctrlPkg::aluNone, 1'b0, 4'h0, 4'h0);
	addVector("ANDI", 16'h1C0F, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'hC, 4'h0, 8'h0F, ctrlPkg::aluAnd, 1'b0, 4'h0, 4'h0);
	addVector("ORI", 16'h24F0, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'h4, 4'h0, 8'hF0, ctrlPkg::aluOr, 1'b0, 4'h0, 4'h0);
	addVector("XORI", 16'h3E55, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'hE, 4'h0, 8'h55, ctrlPkg::aluXor, 1'b0, 4'h0, 4'h0);
	addVector("MOVI", 16'hD0AA, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'h0, 4'h0, 8'hAA, ctrlPkg::aluMov, 1'b0, 4'h0, 4'h0);
	addVector("LUI", 16'hF712, 5'h00, 1'b1, 8'b0001_1110, ctrlPkg::wbAlu,
		4'h7, 4'h0, 8'h12, ctrlPkg::aluLui, 1'b0, 4'h0, 4'h0);

	//////////////////////////////////////////////////
	// R-types
	addVector("ADD", 16'h0354, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'h3, 4'h4, 8'h00, ctrlPkg::aluAdd, 1'b0, 4'h0, 4'h0);
	addVector("ADDU", 16'h0A61, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'hA, 4'h1, 8'h00, ctrlPkg::aluAddu, 1'b0, 4'h0, 4'h0);
	addVector("SUB", 16'h0592, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'h5, 4'h2, 8'h00, ctrlPkg::aluSub, 1'b0, 4'h0, 4'h0);
	addVector("CMP", 16'h06B7, 5'h00, 1'b1, 8'b0000_1100, ctrlPkg::wbAlu,
		4'h6, 4'h7, 8'h00, ctrlPkg::aluNone, 1'b0, 4'h0, 4'h0);
	addVector("AND", 16'h081F, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'h8, 4'hF, 8'h00, ctrlPkg::aluAnd, 1'b0, 4'h0, 4'h0);
	addVector("OR", 16'h0923, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'h9, 4'h3, 8'h00, ctrlPkg::aluOr, 1'b0, 4'h0, 4'h0);
	addVector("XOR", 16'h0B3C, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'hB, 4'hC, 8'h00, ctrlPkg::aluXor, 1'b0, 4'h0, 4'h0);
	addVector("MOV", 16'h0FD0, 5'h00, 1'b1, 8'b0000_1110, ctrlPkg::wbAlu,
		4'hF, 4'h0, 8'h00, ctrlPkg::aluMov, 1'b0, 4'h0, 4'h0);

	//////////////////////////////////////////////////
	// Shifts
	addVector("LSH", 16'h8245, 5'h00, 1'b1, 8'b0000_0110, ctrlPkg::wbAlu,
		4'h2, 4'h5, 8'h00, ctrlPkg::aluSll, 1'b0, 4'h0, 4'h0);
	addVector("ASHU", 16'h8C6A, 5'h00, 1'b1, 8'b0000_0110, ctrlPkg::wbAlu,
		4'hC, 4'hA, 8'h00, ctrlPkg::aluSla, 1'b0, 4'h0, 4'h0);
	addVector("LLSHI", 16'h8307, 5'h00, 1'b1, 8'b0000_0110, ctrlPkg::wbAlu,
		4'h3, 4'h0, 8'h07, ctrlPkg::aluSll, 1'b0, 4'h0, 4'h0);
	addVector("LRSHI", 16'h851F, 5'h00, 1'b1, 8'b0000_0110, ctrlPkg::wbAlu,
		4'h5, 4'h0, 8'h0F, ctrlPkg::aluSrl, 1'b0, 4'h0, 4'h0);
	addVector("ALSHUI", 16'h8629, 5'h00, 1'b1, 8'b0000_0110, ctrlPkg::wbAlu,
		4'h6, 4'h0, 8'h09, ctrlPkg::aluSla, 1'b0, 4'h0, 4'h0);
	addVector("ARSHUI", 16'h8E3E, 5'h00, 1'b1, 8'b0000_0110, ctrlPkg::wbAlu,
		4'hE, 4'h0, 8'h0E, ctrlPkg::aluSra, 1'b0, 4'h0, 4'h0);

	//////////////////////////////////////////////////
	// Memory and link
	addVector("LOAD", 16'h4706, 5'h00, 1'b1, 8'b0010_0000, ctrlPkg::wbAlu,
		4'h0, 4'h6, 8'h00, ctrlPkg::aluNone, 1'b1, 4'h7, 4'h6);
	addVector("LOAD r12", 16'h4C03, 5'h00, 1'b1, 8'b0010_0000, ctrlPkg::wbAlu,
		4'h0, 4'h3, 8'h00, ctrlPkg::aluNone, 1'b1, 4'hC, 4'h3);
	addVector("STOR", 16'h4A4B, 5'h00, 1'b1, 8'b0010_0100, ctrlPkg::wbAlu,
		4'hA, 4'hB, 8'h00, ctrlPkg::aluNone, 1'b0, 4'h0, 4'h0);
	addVector("JAL", 16'h4385, 5'h00, 1'b1, 8'b0100_0110, ctrlPkg::wbLink,
		4'hF, 4'h5, 8'h00, ctrlPkg::aluNone, 1'b0, 4'h0, 4'h0);

	// PSR bits are N Z F L C from the top
	addCond(ctrlPkg::EQ, 5'b01000, 1'b1, 5'b00000);
	addCond(ctrlPkg::NE, 5'b00000, 1'b1, 5'b01000);
	addCond(ctrlPkg::CS, 5'b00001, 1'b1, 5'b00000);
	addCond(ctrlPkg::CC, 5'b00000, 1'b1, 5'b00001);
	addCond(ctrlPkg::HI, 5'b00010, 1'b1, 5'b00000);
	addCond(ctrlPkg::LS, 5'b00000, 1'b1, 5'b00010);
	addCond(ctrlPkg::GT, 5'b10000, 1'b1, 5'b00000);
	addCond(ctrlPkg::LE, 5'b00000, 1'b1, 5'b10000);
	addCond(ctrlPkg::FS, 5'b00100, 1'b1, 5'b00000);
	addCond(ctrlPkg::FC, 5'b00000, 1'b1, 5'b00100);
	addCond(ctrlPkg::LO, 5'b10101, 1'b1, 5'b00010);
	addCond(ctrlPkg::HS, 5'b01000, 1'b1, 5'b10101);
	addCond(ctrlPkg::LT, 5'b00111, 1'b1, 5'b10000);
	addCond(ctrlPkg::GE, 5'b10000, 1'b1, 5'b00111);
	// UC stays false even with every flag set
	addCond(ctrlPkg::UC, 5'b11111, 1'b0, 5'b00000);
endtask

`endif

/* tests/controllerTb.sv */
`timescale 1ns/10ps

module controllerTb;

	`include "controllerVectors.svh"

	logic clk;
	logic rst;
	ctrlPkg::psr_t psr;
	ctrlPkg::inst_t inst;
	logic branch;
	logic jump;
	logic memcMux;
	logic immMux;
	logic psrEn;
	logic pcEn;
	logic write;
	logic condRslt;
	ctrlPkg::wbSel_t wbMux;
	ctrlPkg::regIdx_t rDst;
	ctrlPkg::regIdx_t rSrc;
	ctrlPkg::imm_t immVal;
	ctrlPkg::aluOp_t aluOp;

	int seed = 40;
	int mismatchCount = 0;
	int otherCount = 0;
	int vectorCount = 0;
	logic timedOut = 1'b0;
	vecRow_t vecTable[$];
	string vecNames[$];
	condRow_t condTable[$];
	string kindNames[3] = '{"BCOND", "JCOND", "SCOND"};

	controller dut
	(
		.clk(clk),
		.rst(rst),
		.psr(psr),
		.inst(inst),
		.branch(branch),
		.jump(jump),
		.memcMux(memcMux),
		.immMux(immMux),
		.psrEn(psrEn),
		.pcEn(pcEn),
		.write(write),
		.condRslt(condRslt),
		.wbMux(wbMux),
		.rDst(rDst),
		.rSrc(rSrc),
		.immVal(immVal),
		.aluOp(aluOp)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Table building
	task automatic addVector(input string name, input ctrlPkg::inst_t rowInst,
		input ctrlPkg::psr_t rowPsr, input logic randFlag, input logic [7:0] strobes,
		input ctrlPkg::wbSel_t wb, input ctrlPkg::regIdx_t dst, input ctrlPkg::regIdx_t src,
		input ctrlPkg::imm_t imm, input ctrlPkg::aluOp_t alu, input logic isLoad,
		input ctrlPkg::regIdx_t ldDst, input ctrlPkg::regIdx_t ldSrc);
		vecRow_t row;
		row = '{rowInst, rowPsr, randFlag, strobes, wb, dst, src, imm, alu, isLoad, ldDst, ldSrc};
		vecTable.push_back(row);
		vecNames.push_back(name);
	endtask

	task automatic addCond(input ctrlPkg::cond_t code, input ctrlPkg::psr_t psrA,
		input logic metA, input ctrlPkg::psr_t psrB);
		condRow_t row;
		row = '{code, psrA, metA, psrB};
		condTable.push_back(row);
	endtask

	// Kind 0 is BCOND, 1 is JCOND, 2 is SCOND
	function automatic vecRow_t condVector(input int kind, input ctrlPkg::cond_t code,
		input ctrlPkg::psr_t rowPsr, input logic met);
		vecRow_t row;
		row = '0;
		row.psr = rowPsr;
		row.wb = ctrlPkg::wbAlu;
		row.alu = ctrlPkg::aluNone;
		case (kind)
			0:
			begin
				row.inst = {ctrlPkg::BCOND, 4'h0, 4'h5, code};
				row.imm = {4'h5, code};
				row.strobes = {met, 7'b0010100};
			end
			1:
			begin
				// Condition sits in the destination field
				row.inst = {ctrlPkg::OTYPE, code, ctrlPkg::JCOND, 4'h9};
				row.src = 4'h9;
				row.strobes = {1'b0, met, 6'b000100};
			end
			default:
			begin
				row.inst = {ctrlPkg::OTYPE, 4'h6, ctrlPkg::SCOND, code};
				row.dst = 4'h6;
				row.wb = ctrlPkg::wbCond;
				row.strobes = {7'b0000011, met};
			end
		endcase
		return row;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	task automatic checkFlag(input string name, input string field, input logic expVal,
		input logic actVal);
		if (actVal !== expVal)
		begin
			mismatchCount++;
			$display("FAIL %s %s expected %b actual %b", name, field, expVal, actVal);
		end
	endtask

	task automatic checkReg(input string name, input string field,
		input ctrlPkg::regIdx_t expVal, input ctrlPkg::regIdx_t actVal);
		if (actVal !== expVal)
		begin
			mismatchCount++;
			$display("FAIL %s %s expected %0d actual %0d", name, field, expVal, actVal);
		end
	endtask

	task automatic checkImm(input string name, input ctrlPkg::imm_t expVal,
		input ctrlPkg::imm_t actVal);
		if (actVal !== expVal)
		begin
			mismatchCount++;
			$display("FAIL %s immVal expected %h actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkAluOp(input string name, input ctrlPkg::aluOp_t expVal,
		input ctrlPkg::aluOp_t actVal);
		if (actVal !== expVal)
		begin
			mismatchCount++;
			$display("FAIL %s aluOp expected %0d actual %0d", name, expVal, actVal);
		end
	endtask

	task automatic checkWb(input string name, input ctrlPkg::wbSel_t expVal,
		input ctrlPkg::wbSel_t actVal);
		if (actVal !== expVal)
		begin
			mismatchCount++;
			$display("FAIL %s wbMux expected %0d actual %0d", name, expVal, actVal);
		end
	endtask

	task automatic compareAll(input string name, input logic [7:0] strobes,
		input ctrlPkg::wbSel_t wb, input ctrlPkg::regIdx_t dst, input ctrlPkg::regIdx_t src,
		input ctrlPkg::imm_t imm, input ctrlPkg::aluOp_t alu);
		checkFlag(name, "branch", strobes[7], branch);
		checkFlag(name, "jump", strobes[6], jump);
		checkFlag(name, "memcMux", strobes[5], memcMux);
		checkFlag(name, "immMux", strobes[4], immMux);
		checkFlag(name, "psrEn", strobes[3], psrEn);
		checkFlag(name, "pcEn", strobes[2], pcEn);
		checkFlag(name, "write", strobes[1], write);
		checkFlag(name, "condRslt", strobes[0], condRslt);
		checkWb(name, wb, wbMux);
		checkReg(name, "rDst", dst, rDst);
		checkReg(name, "rSrc", src, rSrc);
		checkImm(name, imm, immVal);
		checkAluOp(name, alu, aluOp);
	endtask

	//////////////////////////////////////////////////
	// Sequencing
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		rst = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			@(posedge clk);
			#1;
			// A JAL on the bus must not leak through reset
			inst = {ctrlPkg::OTYPE, 4'h3, ctrlPkg::JAL, 4'h5};
			#2;
			compareAll("reset", 8'h00, ctrlPkg::wbAlu, 4'h0, 4'h0, 8'h00, ctrlPkg::aluNone);
		end
		nextCycle();
		rst = 1'b1;
	endtask

	// Starts and ends one delay step after the edge that opens a fetch cycle
	task automatic runVector(input vecRow_t row, input string name);
		int cycles;
		int lastCycle;
		logic ended;
		cycles = 0;
		ended = 1'b0;
		lastCycle = row.isLoad ? 2 : 1;
		vectorCount++;
		inst = row.inst;
		psr = row.randPsr ? ctrlPkg::psr_t'($random(seed)) : row.psr;
		#2;
		compareAll({name, " fetch"}, 8'h00, ctrlPkg::wbAlu, 4'h0, 4'h0, 8'h00,
			ctrlPkg::aluNone);
		// pcEn closes the instruction within four cycles
		while (!ended && cycles < 4)
		begin
			nextCycle();
			#2;
			cycles++;
			if (cycles == 1)
				compareAll(name, row.strobes, row.wb, row.dst, row.src, row.imm, row.alu);
			else if (cycles == 2 && row.isLoad)
				compareAll({name, " load"}, 8'b0010_0110, ctrlPkg::wbMem, row.ldDst,
					row.ldSrc, 8'h00, ctrlPkg::aluNone);
			ended = (pcEn === 1'b1);
		end
		if (!ended)
		begin
			otherCount++;
			timedOut = 1'b1;
			$display("Timeout in %s, pcEn never went high within 4 cycles", name);
		end
		else
		begin
			if (cycles != lastCycle)
			begin
				otherCount++;
				$display("%s took %0d cycles after fetch instead of %0d", name, cycles,
					lastCycle);
			end
			nextCycle();
		end
	endtask

	initial
	begin
		rst = 1'b0;
		inst = '0;
		psr = '0;
		fillTables();
		applyReset();
		for (int i = 0; i < vecTable.size() && !timedOut; i++)
			runVector(vecTable[i], vecNames[i]);
		for (int k = 0; k < 3 && !timedOut; k++)
		begin
			for (int c = 0; c < condTable.size() && !timedOut; c++)
			begin
				runVector(condVector(k, condTable[c].code, condTable[c].psrA, condTable[c].metA),
					$sformatf("%s code %0d psr %b", kindNames[k], condTable[c].code,
					condTable[c].psrA));
				if (!timedOut)
					runVector(condVector(k, condTable[c].code, condTable[c].psrB, 1'b0),
						$sformatf("%s code %0d psr %b", kindNames[k], condTable[c].code,
						condTable[c].psrB));
			end
		end
		$display("Ran %0d vectors with %0d mismatches and %0d other errors", vectorCount,
			mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tests/controller_checker.sv */
`timescale 1ns/10ps

module controller_checker
(
	input logic clk,
	input logic rst,
	input logic branch,
	input logic jump,
	input logic memcMux,
	input logic immMux,
	input logic psrEn,
	input logic pcEn,
	input logic write,
	input logic condRslt
);

	// Register writes only land in the closing cycle
	assert property (@(posedge clk) disable iff (!rst) write |-> pcEn)
		else $error("write high without pcEn");

	// Every instruction is followed by a fetch
	assert property (@(posedge clk) disable iff (!rst) pcEn |=> !pcEn)
		else $error("pcEn high in two consecutive cycles");

	assert property (@(posedge clk) !(branch && jump))
		else $error("branch and jump high together");

	assert property (@(posedge clk) !rst |->
		!(branch || jump || memcMux || immMux || psrEn || pcEn || write || condRslt))
		else $error("strobe active during reset");

endmodule

bind controller controller_checker checkerInst
(
	.clk(clk),
	.rst(rst),
	.branch(branch),
	.jump(jump),
	.memcMux(memcMux),
	.immMux(immMux),
	.psrEn(psrEn),
	.pcEn(pcEn),
	.write(write),
	.condRslt(condRslt)
);

/* source/controller.sv */
`timescale 1ns/10ps

module controller
(
	input logic clk,
	input logic rst,
	input ctrlPkg::psr_t psr,
	input ctrlPkg::inst_t inst,
	output logic branch,
	output logic jump,
	output logic memcMux,
	output logic immMux,
	output logic psrEn,
	output logic pcEn,
	output logic write,
	output logic condRslt,
	output ctrlPkg::wbSel_t wbMux,
	output ctrlPkg::regIdx_t rDst,
	output ctrlPkg::regIdx_t rSrc,
	output ctrlPkg::imm_t immVal,
	output ctrlPkg::aluOp_t aluOp
);

	ctrlPkg::phase_t phase;
	logic loadStart;

	ctrlSequencer ctrlSequencerInst
	(
		.clk(clk),
		.rst(rst),
		.loadStart(loadStart),
		.phase(phase)
	);

	// Outputs follow phase, inst and psr in the same cycle
	instDecode instDecodeInst
	(
		.phase(phase),
		.inst(inst),
		.psr(psr),
		.loadStart(loadStart),
		.branch(branch),
		.jump(jump),
		.memcMux(memcMux),
		.immMux(immMux),
		.psrEn(psrEn),
		.pcEn(pcEn),
		.write(write),
		.condRslt(condRslt),
		.wbMux(wbMux),
		.rDst(rDst),
		.rSrc(rSrc),
		.immVal(immVal),
		.aluOp(aluOp)
	);

endmodule

/* source/ctrlSequencer.sv */
`timescale 1ns/10ps

module ctrlSequencer
(
	input logic clk,
	input logic rst,
	input logic loadStart,
	output ctrlPkg::phase_t phase
);

	ctrlPkg::phase_t nextPhase;

	// Phase register
	always_ff @(posedge clk)
	begin
		if (!rst)
			phase <= ctrlPkg::phFetch;
		else
			phase <= nextPhase;
	end

	always_comb
	begin
		case (phase)
			ctrlPkg::phFetch: nextPhase = ctrlPkg::phDecode;
			// Only LOAD needs the extra cycle
			ctrlPkg::phDecode: nextPhase = loadStart ? ctrlPkg::phLoad : ctrlPkg::phFetch;
			ctrlPkg::phLoad: nextPhase = ctrlPkg::phFetch;
			default: nextPhase = ctrlPkg::phFetch;
		endcase
	end

endmodule

/* source/instDecode.sv */
`timescale 1ns/10ps

module instDecode
(
	input ctrlPkg::phase_t phase,
	input ctrlPkg::inst_t inst,
	input ctrlPkg::psr_t psr,
	output logic loadStart,
	output logic branch,
	output logic jump,
	output logic memcMux,
	output logic immMux,
	output logic psrEn,
	output logic pcEn,
	output logic write,
	output logic condRslt,
	output ctrlPkg::wbSel_t wbMux,
	output ctrlPkg::regIdx_t rDst,
	output ctrlPkg::regIdx_t rSrc,
	output ctrlPkg::imm_t immVal,
	output ctrlPkg::aluOp_t aluOp
);

	ctrlPkg::opcode_t opcode;
	ctrlPkg::opEx_t opEx;
	ctrlPkg::regIdx_t dstField;
	ctrlPkg::regIdx_t srcField;
	ctrlPkg::imm_t immField;
	ctrlPkg::cond_t condSel;
	logic condMet;
	logic isJcond;

	// I-type opcodes and R-type extensions use the same codes
	function automatic ctrlPkg::aluOp_t aluFor(input ctrlPkg::opcode_t code);
		case (code)
			ctrlPkg::ADDI: return ctrlPkg::aluAdd;
			ctrlPkg::ADDUI: return ctrlPkg::aluAddu;
			ctrlPkg::SUBI: return ctrlPkg::aluSub;
			ctrlPkg::ANDI: return ctrlPkg::aluAnd;
			ctrlPkg::ORI: return ctrlPkg::aluOr;
			ctrlPkg::XORI: return ctrlPkg::aluXor;
			ctrlPkg::MOVI: return ctrlPkg::aluMov;
			ctrlPkg::LUI: return ctrlPkg::aluLui;
			default: return ctrlPkg::aluNone;
		endcase
	endfunction

	assign opcode = inst[ctrlPkg::opHi:ctrlPkg::opLo];
	assign opEx = inst[ctrlPkg::exHi:ctrlPkg::exLo];
	assign dstField = inst[ctrlPkg::dstHi:ctrlPkg::dstLo];
	assign srcField = inst[ctrlPkg::srcHi:ctrlPkg::srcLo];
	assign immField = inst[ctrlPkg::immHi:ctrlPkg::immLo];

	assign isJcond = (opcode == ctrlPkg::OTYPE) && (opEx == ctrlPkg::JCOND);
	assign loadStart = (opcode == ctrlPkg::OTYPE) && (opEx == ctrlPkg::LOAD);

	// JCOND carries its condition in the destination field
	assign condSel = isJcond ? dstField : srcField;

	condEval condEvalInst
	(
		.psr(psr),
		.condSel(condSel),
		.condMet(condMet)
	);

	always_comb
	begin
		branch = 1'b0;
		jump = 1'b0;
		memcMux = 1'b0;
		immMux = 1'b0;
		psrEn = 1'b0;
		pcEn = 1'b0;
		write = 1'b0;
		condRslt = 1'b0;
		wbMux = ctrlPkg::wbAlu;
		rDst = '0;
		rSrc = '0;
		immVal = '0;
		aluOp = ctrlPkg::aluNone;

		case (phase)
			ctrlPkg::phDecode:
			begin
				case (opcode)
					//////////////////////////////////////////////////
					// I-types, CMPI only sets flags
					ctrlPkg::ADDI, ctrlPkg::ADDUI, ctrlPkg::SUBI, ctrlPkg::CMPI,
					ctrlPkg::ANDI, ctrlPkg::ORI, ctrlPkg::XORI, ctrlPkg::MOVI, ctrlPkg::LUI:
					begin
						rDst = dstField;
						immVal = immField;
						aluOp = aluFor(opcode);
						immMux = 1'b1;
						write = (opcode != ctrlPkg::CMPI);
						psrEn = 1'b1;
						pcEn = 1'b1;
					end

					//////////////////////////////////////////////////
					// R-types
					ctrlPkg::RTYPE:
					begin
						case (opEx)
							ctrlPkg::ADD, ctrlPkg::ADDU, ctrlPkg::SUB, ctrlPkg::CMP,
							ctrlPkg::AND, ctrlPkg::OR, ctrlPkg::XOR, ctrlPkg::MOV:
							begin
								rDst = dstField;
								rSrc = srcField;
								aluOp = aluFor(opEx);
								write = (opEx != ctrlPkg::CMP);
								psrEn = 1'b1;
								pcEn = 1'b1;
							end
							default: ;
						endcase
					end

					//////////////////////////////////////////////////
					// Memory, set and jump
					ctrlPkg::OTYPE:
					begin
						case (opEx)
							ctrlPkg::LOAD:
							begin
								// Write-back follows in the load phase
								rSrc = srcField;
								memcMux = 1'b1;
							end
							ctrlPkg::STOR:
							begin
								rDst = dstField;
								rSrc = srcField;
								memcMux = 1'b1;
								pcEn = 1'b1;
							end
							ctrlPkg::SCOND:
							begin
								rDst = dstField;
								wbMux = ctrlPkg::wbCond;
								write = 1'b1;
								pcEn = 1'b1;
								condRslt = condMet;
							end
							ctrlPkg::JCOND:
							begin
								rSrc = srcField;
								pcEn = 1'b1;
								jump = condMet;
							end
							ctrlPkg::JAL:
							begin
								jump = 1'b1;
								rDst = ctrlPkg::linkReg;
								rSrc = srcField;
								write = 1'b1;
								wbMux = ctrlPkg::wbLink;
								pcEn = 1'b1;
							end
							default: ;
						endcase
					end

					ctrlPkg::BCOND:
					begin
						immVal = immField;
						immMux = 1'b1;
						pcEn = 1'b1;
						branch = condMet;
					end

					//////////////////////////////////////////////////
					// Shifts leave the flags alone
					ctrlPkg::STYPE:
					begin
						case (opEx)
							ctrlPkg::LSH, ctrlPkg::ASHU:
							begin
								rDst = dstField;
								rSrc = srcField;
								aluOp = (opEx == ctrlPkg::LSH) ? ctrlPkg::aluSll : ctrlPkg::aluSla;
								write = 1'b1;
								pcEn = 1'b1;
							end
							ctrlPkg::LLSHI, ctrlPkg::LRSHI, ctrlPkg::ALSHUI, ctrlPkg::ARSHUI:
							begin
								rDst = dstField;
								// Shift amount is the low nibble
								immVal = ctrlPkg::imm_t'(srcField);
								case (opEx)
									ctrlPkg::LLSHI: aluOp = ctrlPkg::aluSll;
									ctrlPkg::LRSHI: aluOp = ctrlPkg::aluSrl;
									ctrlPkg::ALSHUI: aluOp = ctrlPkg::aluSla;
									default: aluOp = ctrlPkg::aluSra;
								endcase
								write = 1'b1;
								pcEn = 1'b1;
							end
							default: ;
						endcase
					end

					default: ;
				endcase
			end

			ctrlPkg::phLoad:
			begin
				rDst = dstField;
				rSrc = srcField;
				memcMux = 1'b1;
				write = 1'b1;
				wbMux = ctrlPkg::wbMem;
				pcEn = 1'b1;
			end

			// Fetch keeps every output idle
			default: ;
		endcase
	end

endmodule

/* source/condEval.sv */
`timescale 1ns/10ps

module condEval
(
	input ctrlPkg::psr_t psr,
	input ctrlPkg::cond_t condSel,
	output logic condMet
);

	logic flagZ;
	logic flagC;
	logic flagL;
	logic flagF;
	logic flagN;

	assign flagZ = psr[ctrlPkg::psrZ];
	assign flagC = psr[ctrlPkg::psrC];
	assign flagL = psr[ctrlPkg::psrL];
	assign flagF = psr[ctrlPkg::psrF];
	assign flagN = psr[ctrlPkg::psrN];

	always_comb
	begin
		case (condSel)
			// Single flag set
			ctrlPkg::EQ: condMet = flagZ;
			ctrlPkg::CS: condMet = flagC;
			ctrlPkg::HI: condMet = flagL;
			ctrlPkg::GT: condMet = flagN;
			ctrlPkg::FS: condMet = flagF;
			ctrlPkg::HS: condMet = flagZ | flagL;
			ctrlPkg::GE: condMet = flagZ | flagN;
			// Inverted forms
			ctrlPkg::NE: condMet = !flagZ;
			ctrlPkg::CC: condMet = !flagC;
			ctrlPkg::LS: condMet = !flagL;
			ctrlPkg::LE: condMet = !flagN;
			ctrlPkg::FC: condMet = !flagF;
			ctrlPkg::LO: condMet = !flagZ && !flagL;
			ctrlPkg::LT: condMet = !flagZ && !flagN;
			// UC never fires, same as the processor it came from
			ctrlPkg::UC: condMet = 1'b0;
			default: condMet = 1'b0;
		endcase
	end

endmodule

/* source/ctrlPkg.sv */
package ctrlPkg;

	//////////////////////////////////////////////////
	// Widths
	localparam int instWidth = 16;
	localparam int opWidth = 4;
	localparam int regWidth = 4;
	localparam int immWidth = 8;
	localparam int condWidth = 4;
	localparam int opExWidth = 4;
	localparam int aluOpWidth = 4;
	localparam int psrWidth = 5;

	typedef logic [instWidth-1:0] inst_t;
	typedef logic [opWidth-1:0] opcode_t;
	typedef logic [regWidth-1:0] regIdx_t;
	typedef logic [immWidth-1:0] imm_t;
	typedef logic [condWidth-1:0] cond_t;
	typedef logic [opExWidth-1:0] opEx_t;
	typedef logic [aluOpWidth-1:0] aluOp_t;
	typedef logic [psrWidth-1:0] psr_t;

	// Write-back source and sequencer phase
	typedef enum logic [1:0] {wbLink = 2'd0, wbCond = 2'd1, wbAlu = 2'd2, wbMem = 2'd3} wbSel_t;
	typedef enum logic [1:0] {phFetch, phDecode, phLoad} phase_t;

	//////////////////////////////////////////////////
	// Instruction fields
	localparam int opHi = 15;
	localparam int opLo = 12;
	localparam int dstHi = 11;
	localparam int dstLo = 8;
	localparam int exHi = 7;
	localparam int exLo = 4;
	localparam int srcHi = 3;
	localparam int srcLo = 0;
	localparam int immHi = 7;
	localparam int immLo = 0;

	localparam regIdx_t linkReg = 4'd15;

	// PSR bits
	localparam int psrC = 0;
	localparam int psrL = 1;
	localparam int psrF = 2;
	localparam int psrZ = 3;
	localparam int psrN = 4;

	//////////////////////////////////////////////////
	// Major opcodes
	localparam opcode_t RTYPE = 4'd0;
	localparam opcode_t ANDI = 4'd1;
	localparam opcode_t ORI = 4'd2;
	localparam opcode_t XORI = 4'd3;
	localparam opcode_t OTYPE = 4'd4;
	localparam opcode_t ADDI = 4'd5;
	localparam opcode_t ADDUI = 4'd6;
	localparam opcode_t STYPE = 4'd8;
	localparam opcode_t SUBI = 4'd9;
	localparam opcode_t CMPI = 4'd11;
	localparam opcode_t BCOND = 4'd12;
	localparam opcode_t MOVI = 4'd13;
	localparam opcode_t LUI = 4'd15;

	// R-type extensions share the I-type codes
	localparam opEx_t AND = 4'd1;
	localparam opEx_t OR = 4'd2;
	localparam opEx_t XOR = 4'd3;
	localparam opEx_t ADD = 4'd5;
	localparam opEx_t ADDU = 4'd6;
	localparam opEx_t SUB = 4'd9;
	localparam opEx_t CMP = 4'd11;
	localparam opEx_t MOV = 4'd13;

	// O-type extensions
	localparam opEx_t LOAD = 4'd0;
	localparam opEx_t STOR = 4'd4;
	localparam opEx_t JAL = 4'd8;
	localparam opEx_t JCOND = 4'd12;
	localparam opEx_t SCOND = 4'd13;

	// Shift extensions
	localparam opEx_t LLSHI = 4'd0;
	localparam opEx_t LRSHI = 4'd1;
	localparam opEx_t ALSHUI = 4'd2;
	localparam opEx_t ARSHUI = 4'd3;
	localparam opEx_t LSH = 4'd4;
	localparam opEx_t ASHU = 4'd6;

	//////////////////////////////////////////////////
	// Condition codes
	localparam cond_t EQ = 4'd0;
	localparam cond_t NE = 4'd1;
	localparam cond_t CS = 4'd2;
	localparam cond_t CC = 4'd3;
	localparam cond_t HI = 4'd4;
	localparam cond_t LS = 4'd5;
	localparam cond_t GT = 4'd6;
	localparam cond_t LE = 4'd7;
	localparam cond_t FS = 4'd8;
	localparam cond_t FC = 4'd9;
	localparam cond_t LO = 4'd10;
	localparam cond_t HS = 4'd11;
	localparam cond_t LT = 4'd12;
	localparam cond_t GE = 4'd13;
	localparam cond_t UC = 4'd14;

	// ALU operations
	localparam aluOp_t aluNone = 4'd0;
	localparam aluOp_t aluAdd = 4'd1;
	localparam aluOp_t aluAddu = 4'd2;
	localparam aluOp_t aluSub = 4'd3;
	localparam aluOp_t aluAnd = 4'd4;
	localparam aluOp_t aluOr = 4'd5;
	localparam aluOp_t aluXor = 4'd6;
	localparam aluOp_t aluMov = 4'd7;
	localparam aluOp_t aluLui = 4'd8;
	localparam aluOp_t aluSll = 4'd9;
	localparam aluOp_t aluSrl = 4'd10;
	localparam aluOp_t aluSla = 4'd11;
	localparam aluOp_t aluSra = 4'd12;

endpackage
